//--- common/lockstep_pkg.sv
// Bus widths are fixed at 32-bit data and address; changing them changes both compared vectors
package lockstep_pkg;

  ////////////////////////////////////////
  // Bus geometry
  ////////////////////////////////////////

  localparam int unsigned DataWidth = 32;
  localparam int unsigned AddrWidth = 32;
  localparam int unsigned BeWidth   = 4;

  // Address advance after each completed write
  localparam int unsigned AddrStep  = 4;

  ////////////////////////////////////////
  // Core state
  ////////////////////////////////////////

  typedef enum logic [1:0] {
    IDLE = 2'd0,
    REQ  = 2'd1,
    WAIT = 2'd2
  } core_state_e;

  ////////////////////////////////////////
  // Lockstep vector widths
  ////////////////////////////////////////

  // Compared outputs: {req, we, be, addr, wdata}
  localparam int unsigned core_out_w = 1 + 1 + BeWidth + AddrWidth + DataWidth;

  // Delayed inputs: {gnt, rvalid, rdata, err, fetch_enable}
  localparam int unsigned core_in_w  = 1 + 1 + DataWidth + 1 + 1;

endpackage

//--- core/acc_core.sv
// One outstanding transaction at a time; rdata is accumulated even on an error response
`timescale 1ns/1ps

module acc_core import lockstep_pkg::*; (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic [AddrWidth-1:0] boot_addr_i,
  input  logic                 fetch_enable_i,
  input  logic                 data_gnt_i,
  input  logic                 data_rvalid_i,
  input  logic [DataWidth-1:0] data_rdata_i,
  input  logic                 data_err_i,
  output logic                 data_req_o,
  output logic                 data_we_o,
  output logic [BeWidth-1:0]   data_be_o,
  output logic [AddrWidth-1:0] data_addr_o,
  output logic [DataWidth-1:0] data_wdata_o,
  output logic                 alert_bus_o
);

  core_state_e          state_q, state_d;
  logic [DataWidth-1:0] acc_q, acc_d;
  logic [AddrWidth-1:0] addr_q, addr_d;
  logic [AddrWidth-1:0] cur_addr;
  logic                 addr_loaded_q, addr_loaded_d;
  logic                 phase_q, phase_d;

  // Boot address is used until the first write has advanced the pointer
  assign cur_addr = addr_loaded_q ? addr_q : boot_addr_i;

  ////////////////////////////////////////
  // Next state
  ////////////////////////////////////////

  always_comb begin
    state_d       = state_q;
    acc_d         = acc_q;
    addr_d        = addr_q;
    addr_loaded_d = addr_loaded_q;
    phase_d       = phase_q;

    case (state_q)
      IDLE: begin
        if (fetch_enable_i) begin
          state_d = REQ;
        end
      end
      REQ: begin
        if (data_gnt_i) begin
          state_d = WAIT;
        end
      end
      WAIT: begin
        if (data_rvalid_i) begin
          state_d = fetch_enable_i ? REQ : IDLE;
          phase_d = ~phase_q;
          if (phase_q) begin
            // Write done, move to the next word
            addr_d        = cur_addr + AddrWidth'(AddrStep);
            addr_loaded_d = 1'b1;
          end else begin
            acc_d = acc_q + data_rdata_i;
          end
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q       <= IDLE;
      acc_q         <= '0;
      addr_q        <= '0;
      addr_loaded_q <= 1'b0;
      phase_q       <= 1'b0;
    end else begin
      state_q       <= state_d;
      acc_q         <= acc_d;
      addr_q        <= addr_d;
      addr_loaded_q <= addr_loaded_d;
      phase_q       <= phase_d;
    end
  end

  ////////////////////////////////////////
  // Bus outputs
  ////////////////////////////////////////

  // Everything is zero outside REQ so idle cycles compare equal
  assign data_req_o   = (state_q == REQ);
  assign data_we_o    = data_req_o & phase_q;
  assign data_be_o    = {BeWidth{data_req_o}};
  assign data_addr_o  = data_req_o ? cur_addr : '0;
  assign data_wdata_o = data_req_o ? acc_q : '0;

  assign alert_bus_o  = (state_q == WAIT) & data_rvalid_i & data_err_i;

  // Request and address stay put while waiting for the grant
  a_req_stable: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    data_req_o && !data_gnt_i |=> data_req_o && $stable(data_addr_o)
  );

endmodule

//--- design/shadow_reset_ctrl.sv
// LockstepOffset must be at least 2; shadow reset is released synchronously to clk_i
`timescale 1ns/1ps

module shadow_reset_ctrl #(
  parameter int unsigned LockstepOffset = 2
) (
  input  logic clk_i,
  input  logic rst_ni,
  output logic rst_shadow_no,
  output logic enable_cmp_o
);

  localparam int unsigned CntW = $clog2(LockstepOffset);

  logic [CntW-1:0] cnt_q, cnt_d;
  logic            rst_shadow_set_d, rst_shadow_set_q;
  logic            enable_cmp_q;

  // Counter saturates at the last count and holds the release request
  assign rst_shadow_set_d = (cnt_q == CntW'(LockstepOffset - 1));
  assign cnt_d            = rst_shadow_set_d ? cnt_q : cnt_q + 1'b1;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q            <= '0;
      rst_shadow_set_q <= 1'b0;
      enable_cmp_q     <= 1'b0;
    end else begin
      cnt_q            <= cnt_d;
      rst_shadow_set_q <= rst_shadow_set_d;
      // Compare starts one cycle after the shadow leaves reset
      enable_cmp_q     <= rst_shadow_set_q;
    end
  end

  assign rst_shadow_no = rst_shadow_set_q;
  assign enable_cmp_o  = enable_cmp_q;

  a_enable_in_run: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    enable_cmp_o |-> rst_shadow_no
  );

endmodule

//--- design/lockstep_delay.sv
// Depth must be at least 1; all stages clear to zero on reset and the line never stalls
`timescale 1ns/1ps

module lockstep_delay #(
  parameter int unsigned Width = 1,
  parameter int unsigned Depth = 2
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic [Width-1:0] d_i,
  output logic [Width-1:0] q_o
);

  logic [Depth-1:0][Width-1:0] stage_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      stage_q <= '0;
    end else begin
      stage_q[0] <= d_i;
      for (int unsigned i = 1; i < Depth; i++) begin
        stage_q[i] <= stage_q[i-1];
      end
    end
  end

  // Oldest stage
  assign q_o = stage_q[Depth-1];

endmodule

//--- design/lockstep_cmp.sv
// Main outputs must arrive one cycle later than the shadow outputs; bus alert passes through
`timescale 1ns/1ps

module lockstep_cmp import lockstep_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  enable_cmp_i,
  input  logic [core_out_w-1:0] shadow_out_i,
  input  logic [core_out_w-1:0] main_out_i,
  input  logic                  shadow_alert_bus_i,
  output logic                  alert_major_internal_o,
  output logic                  alert_major_bus_o
);

  logic [core_out_w-1:0] shadow_out_q;
  logic                  outputs_mismatch;

  ////////////////////////////////////////
  // Shadow output register
  ////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    shadow_out_q <= shadow_out_i;
  end

  ////////////////////////////////////////
  // Compare
  ////////////////////////////////////////

  // Any differing bit of req, we, be, addr or wdata counts
  assign outputs_mismatch       = enable_cmp_i & (shadow_out_q != main_out_i);
  assign alert_major_internal_o = outputs_mismatch;

  // Shadow sees bus errors with the input delay already applied
  assign alert_major_bus_o      = shadow_alert_bus_i;

  // While compare is off the shadow is in reset or in its first IDLE cycle, never waiting
  a_quiet_when_disabled: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    !enable_cmp_i |-> !alert_major_internal_o && !alert_major_bus_o
  );

endmodule

//--- design/lockstep_top.sv
// Main core lives outside; its inputs and outputs must be presented here in the same cycle
`timescale 1ns/1ps

module lockstep_top import lockstep_pkg::*; #(
  parameter int unsigned LockstepOffset = 2
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic [AddrWidth-1:0] boot_addr_i,
  input  logic                 fetch_enable_i,
  input  logic                 data_gnt_i,
  input  logic                 data_rvalid_i,
  input  logic [DataWidth-1:0] data_rdata_i,
  input  logic                 data_err_i,
  input  logic                 main_data_req_i,
  input  logic                 main_data_we_i,
  input  logic [BeWidth-1:0]   main_data_be_i,
  input  logic [AddrWidth-1:0] main_data_addr_i,
  input  logic [DataWidth-1:0] main_data_wdata_i,
  output logic                 alert_major_internal_o,
  output logic                 alert_major_bus_o
);

  logic                  rst_shadow_n;
  logic                  enable_cmp;

  // Delayed inputs seen by the shadow
  logic                  shadow_gnt;
  logic                  shadow_rvalid;
  logic [DataWidth-1:0]  shadow_rdata;
  logic                  shadow_err;
  logic                  shadow_fetch_enable;

  // Shadow outputs
  logic                  shadow_req;
  logic                  shadow_we;
  logic [BeWidth-1:0]    shadow_be;
  logic [AddrWidth-1:0]  shadow_addr;
  logic [DataWidth-1:0]  shadow_wdata;
  logic                  shadow_alert_bus;

  logic [core_out_w-1:0] main_out_q;

  shadow_reset_ctrl #(
    .LockstepOffset(LockstepOffset)
  ) u_rst_ctrl (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .rst_shadow_no(rst_shadow_n),
    .enable_cmp_o (enable_cmp)
  );

  ////////////////////////////////////////
  // Delay lines
  ////////////////////////////////////////

  lockstep_delay #(
    .Width(core_in_w),
    .Depth(LockstepOffset)
  ) u_in_delay (
    .clk_i (clk_i),
    .rst_ni(rst_ni),
    .d_i   ({data_gnt_i, data_rvalid_i, data_rdata_i, data_err_i, fetch_enable_i}),
    .q_o   ({shadow_gnt, shadow_rvalid, shadow_rdata, shadow_err, shadow_fetch_enable})
  );

  // One extra stage matches the shadow output register
  lockstep_delay #(
    .Width(core_out_w),
    .Depth(LockstepOffset + 1)
  ) u_out_delay (
    .clk_i (clk_i),
    .rst_ni(rst_ni),
    .d_i   ({main_data_req_i, main_data_we_i, main_data_be_i, main_data_addr_i,
             main_data_wdata_i}),
    .q_o   (main_out_q)
  );

  acc_core u_shadow_core (
    .clk_i         (clk_i),
    .rst_ni        (rst_shadow_n),
    .boot_addr_i   (boot_addr_i),
    .fetch_enable_i(shadow_fetch_enable),
    .data_gnt_i    (shadow_gnt),
    .data_rvalid_i (shadow_rvalid),
    .data_rdata_i  (shadow_rdata),
    .data_err_i    (shadow_err),
    .data_req_o    (shadow_req),
    .data_we_o     (shadow_we),
    .data_be_o     (shadow_be),
    .data_addr_o   (shadow_addr),
    .data_wdata_o  (shadow_wdata),
    .alert_bus_o   (shadow_alert_bus)
  );

  lockstep_cmp u_cmp (
    .clk_i                 (clk_i),
    .rst_ni                (rst_ni),
    .enable_cmp_i          (enable_cmp),
    .shadow_out_i          ({shadow_req, shadow_we, shadow_be, shadow_addr, shadow_wdata}),
    .main_out_i            (main_out_q),
    .shadow_alert_bus_i    (shadow_alert_bus),
    .alert_major_internal_o(alert_major_internal_o),
    .alert_major_bus_o     (alert_major_bus_o)
  );

endmodule

//--- tests/tb_lockstep.sv
// Runs with LockstepOffset 2 from the project root; the first 8 pattern lines are reset cycles
`timescale 1ns/1ps

module tb_lockstep import lockstep_pkg::*; ();

  localparam int unsigned          Offset      = 2;
  localparam int                   ResetCycles = 8;
  localparam int                   MaxCycles   = 400;
  localparam logic [AddrWidth-1:0] BootAddr    = 32'h0000_1000;
  localparam string                PatternFile = "tests/lockstep_patterns.txt";

  logic                 clk_i;
  logic                 rst_ni;
  logic [AddrWidth-1:0] boot_addr_i;
  logic                 fetch_enable_i;
  logic                 data_gnt_i;
  logic                 data_rvalid_i;
  logic [DataWidth-1:0] data_rdata_i;
  logic                 data_err_i;
  logic                 main_data_req_i;
  logic                 main_data_we_i;
  logic [BeWidth-1:0]   main_data_be_i;
  logic [AddrWidth-1:0] main_data_addr_i;
  logic [DataWidth-1:0] main_data_wdata_i;
  logic                 alert_major_internal_o;
  logic                 alert_major_bus_o;

  // Main core model state
  core_state_e          m_state;
  logic [DataWidth-1:0] m_acc;
  logic [AddrWidth-1:0] m_addr;
  logic                 m_phase;

  logic [31:0] rnd_state;
  int          errors;
  int          checks;
  int          tests_run;
  int          tests_failed;
  int          test_errors;
  int          test_cycles;
  int          cur_test;
  bit          timed_out;

  lockstep_top #(
    .LockstepOffset(Offset)
  ) u_dut (
    .clk_i                 (clk_i),
    .rst_ni                (rst_ni),
    .boot_addr_i           (boot_addr_i),
    .fetch_enable_i        (fetch_enable_i),
    .data_gnt_i            (data_gnt_i),
    .data_rvalid_i         (data_rvalid_i),
    .data_rdata_i          (data_rdata_i),
    .data_err_i            (data_err_i),
    .main_data_req_i       (main_data_req_i),
    .main_data_we_i        (main_data_we_i),
    .main_data_be_i        (main_data_be_i),
    .main_data_addr_i      (main_data_addr_i),
    .main_data_wdata_i     (main_data_wdata_i),
    .alert_major_internal_o(alert_major_internal_o),
    .alert_major_bus_o     (alert_major_bus_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic check(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      $display("ERROR at %0d ns: %s is %b, expected %b", $time, name, got, exp);
      errors++;
      test_errors++;
    end
  endtask

  function automatic void reset_model();
    m_state = IDLE;
    m_acc   = '0;
    m_addr  = BootAddr;
    m_phase = 1'b0;
  endfunction

  // One clock of the core rule: read adds rdata, write advances the address
  function automatic void step_model(input logic fe, input logic gnt, input logic rvalid,
                                     input logic [DataWidth-1:0] rdata);
    case (m_state)
      IDLE: begin
        if (fe) m_state = REQ;
      end
      REQ: begin
        if (gnt) m_state = WAIT;
      end
      WAIT: begin
        if (rvalid) begin
          if (m_phase) begin
            m_addr = m_addr + AddrStep;
          end else begin
            m_acc = m_acc + rdata;
          end
          m_phase = ~m_phase;
          m_state = fe ? REQ : IDLE;
        end
      end
      default: m_state = IDLE;
    endcase
  endfunction

  task automatic report_test();
    if (test_errors == 0) begin
      $display("test %0d passed (%0d cycles)", cur_test, test_cycles);
    end else begin
      $display("test %0d failed with %0d errors (%0d cycles)", cur_test, test_errors,
               test_cycles);
      tests_failed++;
    end
  endtask

  ////////////////////////////////////////
  // Pattern loop
  ////////////////////////////////////////

  task automatic run_patterns(input int fd);
    string                line;
    string                rdata_tok;
    int                   n;
    int                   test_no;
    int                   cycle;
    logic                 fe, gnt, rvalid, err, exp_int, exp_bus, req;
    logic [DataWidth-1:0] rdata, mask;
    cycle = 0;
    while (!$feof(fd) && !timed_out) begin
      n = $fgets(line, fd);
      if (n > 0 && line.len() > 1 && line.substr(0, 1) != "//") begin
        n = $sscanf(line, "%d %b %b %b %s %b %h %b %b", test_no, fe, gnt, rvalid,
                    rdata_tok, err, mask, exp_int, exp_bus);
        if (n != 9) begin
          $display("Pattern line could not be read: %s", line);
          errors++;
        end else begin
          if (test_no != cur_test) begin
            if (cur_test >= 0) report_test();
            cur_test    = test_no;
            test_errors = 0;
            test_cycles = 0;
            tests_run++;
          end
          if (rdata_tok == "R") begin
            rnd_state = xorshift32(rnd_state);
            rdata     = rnd_state;
          end else begin
            n = $sscanf(rdata_tok, "%h", rdata);
          end
          req = (m_state == REQ);
          @(posedge clk_i);
          rst_ni            <= (cycle >= ResetCycles);
          fetch_enable_i    <= fe;
          data_gnt_i        <= gnt;
          data_rvalid_i     <= rvalid;
          data_rdata_i      <= rdata;
          data_err_i        <= err;
          main_data_req_i   <= req;
          main_data_we_i    <= req & m_phase;
          main_data_be_i    <= {BeWidth{req}};
          main_data_addr_i  <= req ? m_addr : '0;
          main_data_wdata_i <= (req ? m_acc : '0) ^ mask;
          // Alerts are combinational from flops, settled by the falling edge
          @(negedge clk_i);
          check("alert_major_internal_o", alert_major_internal_o, exp_int);
          check("alert_major_bus_o", alert_major_bus_o, exp_bus);
          if (cycle < ResetCycles) begin
            reset_model();
          end else begin
            step_model(fe, gnt, rvalid, rdata);
          end
          cycle++;
          test_cycles++;
          if (cycle >= MaxCycles) begin
            $display("Pattern loop stopped after %0d cycles before the end of the file",
                     MaxCycles);
            timed_out = 1'b1;
          end
        end
      end
    end
    if (cur_test >= 0) report_test();
  endtask

  initial begin
    int fd;
    rst_ni            = 1'b0;
    boot_addr_i       = BootAddr;
    fetch_enable_i    = 1'b0;
    data_gnt_i        = 1'b0;
    data_rvalid_i     = 1'b0;
    data_rdata_i      = '0;
    data_err_i        = 1'b0;
    main_data_req_i   = 1'b0;
    main_data_we_i    = 1'b0;
    main_data_be_i    = '0;
    main_data_addr_i  = '0;
    main_data_wdata_i = '0;
    rnd_state         = 32'h9783_c5c0;
    errors            = 0;
    checks            = 0;
    tests_run         = 0;
    tests_failed      = 0;
    cur_test          = -1;
    timed_out         = 1'b0;
    reset_model();
    fd = $fopen(PatternFile, "r");
    if (fd == 0) begin
      $display("Could not open the pattern file %s", PatternFile);
      $display("FAIL: see errors above");
      $finish;
    end else begin
      run_patterns(fd);
      $fclose(fd);
      $display("%0d tests, %0d failed, %0d checks, %0d errors", tests_run, tests_failed,
               checks, errors);
      if (errors == 0 && !timed_out && tests_run > 0) begin
        $display("PASS: all tests");
      end else begin
        $display("FAIL: see errors above");
      end
      $finish;
    end
  end

endmodule

//--- lockstep.f
common/lockstep_pkg.sv
core/acc_core.sv
design/shadow_reset_ctrl.sv
design/lockstep_delay.sv
design/lockstep_cmp.sv
design/lockstep_top.sv
tests/tb_lockstep.sv

//--- Makefile
# Verilator build and run of the lockstep checker testbench
VERILATOR ?= verilator
TOP       ?= tb_lockstep
FILELIST  ?= lockstep.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
PASS_MSG  ?= PASS: all tests

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM)

# Rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o V$(TOP)

# Runs from the project root so the pattern file path resolves
run: $(SIM)
	@out="$$($(SIM))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

//--- tests/lockstep_patterns.txt
// test fetch_enable gnt rvalid rdata(hex, R = random) err wdata_mask(hex) exp_internal exp_bus
// One line per clock cycle; the first 8 lines run with rst_ni low
1 1 1 0 00000000 0 DEADBEEF 0 0
1 1 1 1 R        1 00000001 0 0
1 0 1 1 R        1 FFFFFFFF 0 0
1 1 0 1 12345678 0 00FF0000 0 0
1 0 0 1 R        1 80000000 0 0
1 1 1 0 00000000 0 0000FFFF 0 0
1 1 1 1 R        1 A5A5A5A5 0 0
1 0 0 0 00000000 0 00000010 0 0
1 0 0 0 00000000 0 00000000 0 0
1 0 0 0 00000000 0 00000000 0 0
1 0 0 0 00000000 0 00000000 0 0
1 0 0 0 00000000 0 00000000 0 0
1 0 0 0 00000000 0 00000000 0 0
2 1 0 0 00000000 0 00000000 0 0
2 1 0 0 00000000 0 00000000 0 0
2 1 1 0 00000000 0 00000000 0 0
2 1 0 0 00000000 0 00000000 0 0
2 1 0 1 R        0 00000000 0 0
2 1 1 0 00000000 0 00000000 0 0
2 1 0 1 R        0 00000000 0 0
2 1 1 0 00000000 0 00000000 0 0
2 0 0 1 R        0 00000000 0 0
2 1 0 0 00000000 0 00000000 0 0
2 1 0 0 00000000 0 00000000 0 0
2 1 1 0 00000000 0 00000000 0 0
2 1 0 0 00000000 0 00000000 0 0
2 1 0 1 00000000 0 00000000 0 0
2 1 1 0 00000000 0 00000000 0 0
2 1 0 1 R        0 00000000 0 0
3 1 1 0 00000000 0 00000000 0 0
3 1 0 0 00000000 0 00000100 0 0
3 1 0 1 R        0 00000000 0 0
3 1 1 0 00000000 0 00000000 0 0
3 1 0 0 00000000 0 00000000 1 0
3 1 0 1 R        0 00000000 0 0
3 1 0 0 00000000 0 00000000 0 0
4 1 1 0 00000000 0 00000000 0 0
4 1 0 1 R        1 00000000 0 0
4 1 1 0 00000000 0 00000000 0 0
4 1 0 0 00000000 0 00000000 0 1
4 1 0 1 R        0 00000000 0 0
4 1 0 1 R        1 00000000 0 0
4 1 1 0 00000000 0 00000000 0 0
4 1 0 0 00000000 1 00000000 0 0
4 1 0 1 R        0 00000000 0 0
5 1 1 0 00000000 0 00000000 0 0
5 1 0 0 00000000 0 80000000 0 0
5 1 0 1 R        0 00010001 0 0
5 1 1 0 00000000 0 FFFFFFFF 0 0
5 1 0 0 00000000 0 00000000 1 0
5 0 0 1 R        0 00000000 1 0
5 0 0 0 00000000 0 00000000 1 0
5 0 0 0 00000000 0 00000000 0 0
5 0 0 0 00000000 0 00000000 0 0
